/* src/mips_pkg.sv */
package mips_pkg;

    localparam int addr_w     = 32;
    localparam int pfn_w      = 20;
    localparam int page_off_w = 12;

    localparam logic [2:0] cattr_cached = 3'd3;  // cacheable, noncoherent

    // vaddr[31:29] of the unmapped kernel segments
    localparam logic [2:0] seg_kseg0 = 3'b100;
    localparam logic [2:0] seg_kseg1 = 3'b101;

    typedef enum logic [4:0] {
        exc_int  = 5'd0,
        exc_mod  = 5'd1,
        exc_tlbl = 5'd2,
        exc_tlbs = 5'd3,
        exc_adel = 5'd4,
        exc_ades = 5'd5,
        exc_ov   = 5'd12,
        exc_tr   = 5'd13
    } exc_code_e;

    // winning exception of one request
    typedef struct packed {
        logic              valid;
        exc_code_e         code;
        logic              tlb_refill;  // selects the refill vector later on
        logic [addr_w-1:0] badvaddr;
    } exc_info_t;

endpackage

/* src/mem_pkg.sv */
package mem_pkg;

    localparam int strb_w = mips_pkg::addr_w / 8;

    typedef enum logic [3:0] {
        op_none = 4'd0,
        op_lb,
        op_lbu,
        op_lh,
        op_lhu,
        op_lw,
        op_ll,
        op_sb,
        op_sh,
        op_sw,
        op_swl,
        op_swr,
        op_sc
    } mem_op_e;

    typedef struct packed {
        mem_op_e                     op;
        logic [mips_pkg::addr_w-1:0] vaddr;
        logic [mips_pkg::addr_w-1:0] pc;
        logic [mips_pkg::addr_w-1:0] rt_data;
        logic                        interrupt;
        logic                        overflow;
        logic                        trap;
        logic                        prior_exc_valid;  // raised in an earlier stage
        mips_pkg::exc_code_e         prior_exc_code;
        logic                        prior_refill;
    } mem_req_t;

    typedef struct packed {
        logic                        found;
        logic                        valid;
        logic                        dirty;
        logic [mips_pkg::pfn_w-1:0]  pfn;
        logic [2:0]                  cattr;
    } tlb_result_t;

    typedef struct packed {
        logic [mips_pkg::addr_w-1:0] paddr;
        logic                        uncached;
        logic                        mem_en;
        logic                        is_write;
        logic [strb_w-1:0]           wstrb;
        logic [mips_pkg::addr_w-1:0] wdata;
        logic                        sc_result;
        mips_pkg::exc_info_t         exc;
    } mem_rsp_t;

    function automatic logic is_load(mem_op_e op);
        return op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_ll};
    endfunction

    // sc counts as a store
    function automatic logic is_store(mem_op_e op);
        return op inside {op_sb, op_sh, op_sw, op_swl, op_swr, op_sc};
    endfunction

endpackage

/* src/addr_translate.sv */
`timescale 1ns/1ps

module addr_translate (
    input  logic [mips_pkg::addr_w-1:0] vaddr,
    input  mem_pkg::tlb_result_t        tlb,
    input  logic [2:0]                  k0_cattr,
    output logic                        mapped,
    output logic                        uncached,
    output logic [mips_pkg::addr_w-1:0] paddr
);

    logic kseg0;
    logic kseg1;

    assign kseg0 = (vaddr[31:29] == mips_pkg::seg_kseg0);
    assign kseg1 = (vaddr[31:29] == mips_pkg::seg_kseg1);

    // kuseg, ksseg and kseg3 go through the tlb
    assign mapped = ~vaddr[31] | (vaddr[31:30] == 2'b11);

    always_comb begin
        if (mapped) begin
            paddr = {tlb.pfn, vaddr[mips_pkg::page_off_w-1:0]};
        end else begin
            paddr = {3'b000, vaddr[28:0]};  // strip segment bits
        end
    end

    assign uncached = kseg1
                    | (kseg0 & (k0_cattr != mips_pkg::cattr_cached))
                    | (mapped & (tlb.cattr != mips_pkg::cattr_cached));

endmodule

/* src/exc_detect.sv */
`timescale 1ns/1ps

module exc_detect (
    input  mem_pkg::mem_req_t    req,
    input  mem_pkg::tlb_result_t tlb,
    input  logic                 mapped,
    output mips_pkg::exc_info_t  exc
);

    logic ld;
    logic st;
    logic adel;
    logic ades;
    logic tlb_chk;
    logic tlb_miss;
    logic tlb_inv;
    logic tlb_mod;

    assign ld = mem_pkg::is_load(req.op);
    assign st = mem_pkg::is_store(req.op);

    // swl/swr are unaligned by design, never checked
    assign adel = ((req.op inside {mem_pkg::op_lh, mem_pkg::op_lhu}) & req.vaddr[0])
                | ((req.op inside {mem_pkg::op_lw, mem_pkg::op_ll}) & (req.vaddr[1:0] != 2'b00));
    assign ades = ((req.op == mem_pkg::op_sh) & req.vaddr[0])
                | ((req.op inside {mem_pkg::op_sw, mem_pkg::op_sc}) & (req.vaddr[1:0] != 2'b00));

    assign tlb_chk  = (ld | st) & mapped;
    assign tlb_miss = tlb_chk & ~tlb.found;                // refill
    assign tlb_inv  = tlb_chk & tlb.found & ~tlb.valid;
    assign tlb_mod  = tlb_chk & st & tlb.found & tlb.valid & ~tlb.dirty;

    // highest priority first
    always_comb begin
        exc = '0;
        if (req.interrupt) begin
            exc.valid = 1'b1;
            exc.code  = mips_pkg::exc_int;
        end else if (req.prior_exc_valid) begin
            exc.valid      = 1'b1;
            exc.code       = req.prior_exc_code;
            exc.tlb_refill = req.prior_refill;
            exc.badvaddr   = req.pc;  // earlier-stage faults report the pc
        end else if (req.overflow) begin
            exc.valid = 1'b1;
            exc.code  = mips_pkg::exc_ov;
        end else if (req.trap) begin
            exc.valid = 1'b1;
            exc.code  = mips_pkg::exc_tr;
        end else if (ades) begin
            exc.valid    = 1'b1;
            exc.code     = mips_pkg::exc_ades;
            exc.badvaddr = req.vaddr;
        end else if (adel) begin
            exc.valid    = 1'b1;
            exc.code     = mips_pkg::exc_adel;
            exc.badvaddr = req.vaddr;
        end else if (tlb_miss | tlb_inv) begin
            exc.valid      = 1'b1;
            exc.code       = st ? mips_pkg::exc_tlbs : mips_pkg::exc_tlbl;
            exc.tlb_refill = tlb_miss;
            exc.badvaddr   = req.vaddr;
        end else if (tlb_mod) begin
            exc.valid    = 1'b1;
            exc.code     = mips_pkg::exc_mod;
            exc.badvaddr = req.vaddr;
        end
    end

endmodule

/* src/ll_sc_monitor.sv */
`timescale 1ns/1ps

module ll_sc_monitor (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              req_valid,
    input  mem_pkg::mem_req_t req,
    input  logic              exc_valid,
    output logic              sc_ok
);

    logic                        link_bit;
    logic [mips_pkg::addr_w-1:0] link_addr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            link_bit <= 1'b0;
        end else if (req_valid) begin
            if (exc_valid) begin
                link_bit <= 1'b0;
            end else if (req.op == mem_pkg::op_ll) begin
                link_bit <= 1'b1;
            end else if (req.op == mem_pkg::op_sc) begin
                link_bit <= 1'b0;  // pass or fail, one shot
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && !exc_valid && req.op == mem_pkg::op_ll) begin
            link_addr <= req.vaddr;
        end
    end

    assign sc_ok = (req.op == mem_pkg::op_sc) & link_bit & (link_addr == req.vaddr);

endmodule

/* src/store_align.sv */
`timescale 1ns/1ps

module store_align (
    input  mem_pkg::mem_op_e              op,
    input  logic [1:0]                    byte_off,
    input  logic [mips_pkg::addr_w-1:0]   rt_data,
    output logic [mem_pkg::strb_w-1:0]    wstrb_pat,
    output logic [mips_pkg::addr_w-1:0]   wdata
);

    always_comb begin
        wstrb_pat = '0;
        wdata     = rt_data;
        case (op)
            mem_pkg::op_sb: begin
                wstrb_pat = 4'b0001 << byte_off;
                wdata     = {4{rt_data[7:0]}};
            end
            mem_pkg::op_sh: begin
                wstrb_pat = byte_off[1] ? 4'b1100 : 4'b0011;
                wdata     = {2{rt_data[15:0]}};
            end
            mem_pkg::op_sw, mem_pkg::op_sc: begin
                wstrb_pat = 4'b1111;
            end
            mem_pkg::op_swl: begin  // high bytes of rt into the low end of the word
                case (byte_off)
                    2'b00: begin
                        wstrb_pat = 4'b0001;
                        wdata     = {4{rt_data[31:24]}};
                    end
                    2'b01: begin
                        wstrb_pat = 4'b0011;
                        wdata     = {2{rt_data[31:16]}};
                    end
                    2'b10: begin
                        wstrb_pat = 4'b0111;
                        wdata     = {8'b0, rt_data[31:8]};
                    end
                    default: wstrb_pat = 4'b1111;
                endcase
            end
            mem_pkg::op_swr: begin
                case (byte_off)
                    2'b00: wstrb_pat = 4'b1111;
                    2'b01: begin
                        wstrb_pat = 4'b1110;
                        wdata     = {rt_data[23:0], 8'b0};
                    end
                    2'b10: begin
                        wstrb_pat = 4'b1100;
                        wdata     = {2{rt_data[15:0]}};
                    end
                    default: begin
                        wstrb_pat = 4'b1000;
                        wdata     = {4{rt_data[7:0]}};
                    end
                endcase
            end
            default: ;  // loads and none write nothing
        endcase
    end

endmodule

/* src/mem_resp_reg.sv */
`timescale 1ns/1ps

module mem_resp_reg (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        req_valid,
    input  mem_pkg::mem_op_e            op,
    input  logic [mips_pkg::addr_w-1:0] paddr,
    input  logic                        uncached,
    input  mips_pkg::exc_info_t         exc,
    input  logic                        sc_ok,
    input  logic [mem_pkg::strb_w-1:0]  wstrb_pat,
    input  logic [mips_pkg::addr_w-1:0] wdata,
    output logic                        rsp_valid,
    output mem_pkg::mem_rsp_t           rsp
);

    logic              is_sc;
    mem_pkg::mem_rsp_t rsp_d;

    assign is_sc = (op == mem_pkg::op_sc);

    always_comb begin
        rsp_d.paddr     = paddr;
        rsp_d.uncached  = uncached;
        rsp_d.is_write  = mem_pkg::is_store(op) & (~is_sc | sc_ok);
        rsp_d.mem_en    = (op != mem_pkg::op_none) & ~exc.valid & ~(is_sc & ~sc_ok);
        rsp_d.wstrb     = rsp_d.is_write ? wstrb_pat : '0;
        rsp_d.wdata     = wdata;
        rsp_d.sc_result = is_sc & sc_ok;  // goes back to rt
        rsp_d.exc       = exc;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            rsp <= rsp_d;
        end
    end

endmodule

/* src/mem_stage_top.sv */
`timescale 1ns/1ps

module mem_stage_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 req_valid,
    input  mem_pkg::mem_req_t    req,
    input  mem_pkg::tlb_result_t tlb,
    input  logic [2:0]           k0_cattr,  // config.k0
    output logic                 rsp_valid,
    output mem_pkg::mem_rsp_t    rsp
);

    logic                        mapped;
    logic                        uncached;
    logic [mips_pkg::addr_w-1:0] paddr;
    mips_pkg::exc_info_t         exc;
    logic                        sc_ok;
    logic [mem_pkg::strb_w-1:0]  wstrb_pat;
    logic [mips_pkg::addr_w-1:0] wdata;

    addr_translate u_addr_translate (
        .vaddr    (req.vaddr),
        .tlb      (tlb),
        .k0_cattr (k0_cattr),
        .mapped   (mapped),
        .uncached (uncached),
        .paddr    (paddr)
    );

    exc_detect u_exc_detect (
        .req    (req),
        .tlb    (tlb),
        .mapped (mapped),
        .exc    (exc)
    );

    ll_sc_monitor u_ll_sc_monitor (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .exc_valid (exc.valid),
        .sc_ok     (sc_ok)
    );

    store_align u_store_align (
        .op        (req.op),
        .byte_off  (req.vaddr[1:0]),
        .rt_data   (req.rt_data),
        .wstrb_pat (wstrb_pat),
        .wdata     (wdata)
    );

    mem_resp_reg u_mem_resp_reg (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .op        (req.op),
        .paddr     (paddr),
        .uncached  (uncached),
        .exc       (exc),
        .sc_ok     (sc_ok),
        .wstrb_pat (wstrb_pat),
        .wdata     (wdata),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

endmodule

/* tb/mem_stage_sva.sv */
`timescale 1ns/1ps

module mem_stage_sva (
    input logic              clk,
    input logic              arst_n,
    input logic              req_valid,
    input logic              rsp_valid,
    input mem_pkg::mem_rsp_t rsp
);

    int fail_cnt = 0;

    rsp_follows_req: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid |=> rsp_valid)
        else begin
            fail_cnt++;
            $error("rsp_valid missing one cycle after req_valid");
        end

    no_rsp_without_req: assert property (@(posedge clk) disable iff (!arst_n)
        !req_valid |=> !rsp_valid)
        else begin
            fail_cnt++;
            $error("rsp_valid without a request");
        end

    // an enabled access never carries an exception
    en_no_exc: assert property (@(posedge clk) disable iff (!arst_n)
        (rsp_valid && rsp.mem_en) |-> !rsp.exc.valid)
        else begin
            fail_cnt++;
            $error("mem_en together with a valid exception");
        end

    strb_is_write: assert property (@(posedge clk) disable iff (!arst_n)
        (rsp_valid && rsp.wstrb != '0) |-> rsp.is_write)
        else begin
            fail_cnt++;
            $error("wstrb set on a non-write");
        end

endmodule

bind mem_stage_top mem_stage_sva u_mem_stage_sva (
    .clk       (clk),
    .arst_n    (arst_n),
    .req_valid (req_valid),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
);

/* tb/tb_mem_stage.sv */
`timescale 1ns/1ps

module tb_mem_stage;

    logic                 clk;
    logic                 arst_n;
    logic                 req_valid;
    mem_pkg::mem_req_t    req;
    mem_pkg::tlb_result_t tlb;
    logic [2:0]           k0_cattr;
    logic                 rsp_valid;
    mem_pkg::mem_rsp_t    rsp;

    mem_pkg::mem_rsp_t exp_q[$];
    int                cyc_q[$];  // negedge count when each request was driven
    int                cyc;
    int                errors;
    int                checks;
    int                tests;
    int                failed_tests;
    int                test_err0;
    logic              link_bit;  // model of the ll/sc link
    logic [31:0]       link_addr;

    mem_stage_top u_mem_stage_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .tlb       (tlb),
        .k0_cattr  (k0_cattr),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic mem_pkg::mem_rsp_t ref_rsp(mem_pkg::mem_req_t r,
                                                  mem_pkg::tlb_result_t t, logic [2:0] k0,
                                                  logic lbit, logic [31:0] laddr);
        mem_pkg::mem_rsp_t e;
        logic              ld;
        logic              st;
        logic              sc;
        logic              mapped;
        logic              adel;
        logic              ades;
        logic              sc_ok;
        logic [1:0]        off;
        logic [3:0]        strb;
        e      = '0;
        strb   = 4'b0000;
        off    = r.vaddr[1:0];
        ld     = r.op inside {mem_pkg::op_lb, mem_pkg::op_lbu, mem_pkg::op_lh,
                              mem_pkg::op_lhu, mem_pkg::op_lw, mem_pkg::op_ll};
        st     = r.op inside {mem_pkg::op_sb, mem_pkg::op_sh, mem_pkg::op_sw,
                              mem_pkg::op_swl, mem_pkg::op_swr, mem_pkg::op_sc};
        sc     = (r.op == mem_pkg::op_sc);
        mapped = (r.vaddr[31:30] != 2'b10);  // everything but kseg0/kseg1
        e.paddr    = mapped ? {t.pfn, r.vaddr[11:0]} : {3'b000, r.vaddr[28:0]};
        e.uncached = mapped ? (t.cattr != 3'd3) : (r.vaddr[29] || k0 != 3'd3);
        adel = (r.op inside {mem_pkg::op_lh, mem_pkg::op_lhu} && off[0])
            || (r.op inside {mem_pkg::op_lw, mem_pkg::op_ll} && off != 2'b00);
        ades = (r.op == mem_pkg::op_sh && off[0])
            || (r.op inside {mem_pkg::op_sw, mem_pkg::op_sc} && off != 2'b00);
        e.exc.valid = 1'b1;
        if (r.interrupt) begin
            e.exc.code = mips_pkg::exc_int;
        end else if (r.prior_exc_valid) begin
            e.exc.code       = r.prior_exc_code;
            e.exc.tlb_refill = r.prior_refill;
            e.exc.badvaddr   = r.pc;
        end else if (r.overflow) begin
            e.exc.code = mips_pkg::exc_ov;
        end else if (r.trap) begin
            e.exc.code = mips_pkg::exc_tr;
        end else if (ades || adel) begin
            e.exc.code     = ades ? mips_pkg::exc_ades : mips_pkg::exc_adel;
            e.exc.badvaddr = r.vaddr;
        end else if ((ld || st) && mapped && (!t.found || !t.valid)) begin
            e.exc.code       = st ? mips_pkg::exc_tlbs : mips_pkg::exc_tlbl;
            e.exc.tlb_refill = !t.found;
            e.exc.badvaddr   = r.vaddr;
        end else if (st && mapped && !t.dirty) begin
            e.exc.code     = mips_pkg::exc_mod;
            e.exc.badvaddr = r.vaddr;
        end else begin
            e.exc.valid = 1'b0;
        end
        sc_ok       = sc && lbit && (laddr == r.vaddr);
        e.is_write  = st && (!sc || sc_ok);
        e.mem_en    = (r.op != mem_pkg::op_none) && !e.exc.valid && !(sc && !sc_ok);
        e.sc_result = sc && sc_ok;
        e.wdata     = r.rt_data;
        case (r.op)
            mem_pkg::op_sb: begin
                strb    = 4'b0001 << off;
                e.wdata = {4{r.rt_data[7:0]}};
            end
            mem_pkg::op_sh: begin
                strb    = off[1] ? 4'b1100 : 4'b0011;
                e.wdata = {2{r.rt_data[15:0]}};
            end
            mem_pkg::op_sw, mem_pkg::op_sc: strb = 4'b1111;
            mem_pkg::op_swl: begin
                strb = 4'b1111 >> (2'd3 - off);
                case (off)
                    2'd0: e.wdata = {4{r.rt_data[31:24]}};
                    2'd1: e.wdata = {2{r.rt_data[31:16]}};
                    2'd2: e.wdata = {8'h00, r.rt_data[31:8]};
                    default: e.wdata = r.rt_data;
                endcase
            end
            mem_pkg::op_swr: begin
                strb = 4'b1111 << off;
                case (off)
                    2'd0: e.wdata = r.rt_data;
                    2'd1: e.wdata = {r.rt_data[23:0], 8'h00};
                    2'd2: e.wdata = {2{r.rt_data[15:0]}};
                    default: e.wdata = {4{r.rt_data[7:0]}};
                endcase
            end
            default: strb = 4'b0000;
        endcase
        e.wstrb = e.is_write ? strb : 4'b0000;
        return e;
    endfunction

    function automatic mem_pkg::mem_req_t mk_req(mem_pkg::mem_op_e op, logic [31:0] va,
                                                 logic [31:0] rt);
        mem_pkg::mem_req_t r;
        r         = '0;
        r.op      = op;
        r.vaddr   = va;
        r.pc      = 32'h0040_0a00;
        r.rt_data = rt;
        return r;
    endfunction

    function automatic mem_pkg::tlb_result_t mk_tlb(logic f, logic v, logic d, logic [2:0] ca);
        mem_pkg::tlb_result_t t;
        t.found = f;
        t.valid = v;
        t.dirty = d;
        t.pfn   = 20'h1_2345;
        t.cattr = ca;
        return t;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] expv);
        checks++;
        if (got !== expv) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, expv);
            errors++;
        end
    endtask

    task automatic send(input mem_pkg::mem_req_t r, input mem_pkg::tlb_result_t t);
        mem_pkg::mem_rsp_t e;
        @(posedge clk);
        #1;
        e         = ref_rsp(r, t, k0_cattr, link_bit, link_addr);
        req_valid = 1'b1;
        req       = r;
        tlb       = t;
        exp_q.push_back(e);
        cyc_q.push_back(cyc);
        if (e.exc.valid) begin
            link_bit = 1'b0;
        end else if (r.op == mem_pkg::op_ll) begin
            link_bit  = 1'b1;
            link_addr = r.vaddr;
        end else if (r.op == mem_pkg::op_sc) begin
            link_bit = 1'b0;
        end
    endtask

    // stop driving, wait for the queue to empty, report the test
    task automatic end_test(input string name);
        int n;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        n = 0;
        while (exp_q.size() > 0 && n < 10) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() > 0) begin
            $display("timeout: %0d responses never arrived in test %s", exp_q.size(), name);
            $display("Simulation finished: FAIL");
            $finish;
        end
        tests++;
        if (errors != test_err0) begin
            failed_tests++;
        end
        $display("test %-10s done, %0d errors", name, errors - test_err0);
        test_err0 = errors;
    endtask

    // response checker, sampled mid-cycle
    initial begin
        mem_pkg::mem_rsp_t e;
        int                at;
        forever begin
            @(negedge clk);
            cyc++;
            if (rsp_valid) begin
                if (exp_q.size() == 0) begin
                    $display("time %0t: response arrived with no request outstanding", $time);
                    errors++;
                end else begin
                    e  = exp_q.pop_front();
                    at = cyc_q.pop_front();
                    check_val("rsp_valid cycle", cyc, at + 2);
                    check_val("paddr", rsp.paddr, e.paddr);
                    check_val("uncached", rsp.uncached, e.uncached);
                    check_val("mem_en", rsp.mem_en, e.mem_en);
                    check_val("is_write", rsp.is_write, e.is_write);
                    check_val("wstrb", rsp.wstrb, e.wstrb);
                    check_val("wdata", rsp.wdata, e.wdata);
                    check_val("sc_result", rsp.sc_result, e.sc_result);
                    check_val("exc.valid", rsp.exc.valid, e.exc.valid);
                    check_val("exc.code", rsp.exc.code, e.exc.code);
                    check_val("exc.tlb_refill", rsp.exc.tlb_refill, e.exc.tlb_refill);
                    check_val("exc.badvaddr", rsp.exc.badvaddr, e.exc.badvaddr);
                end
            end else if (cyc_q.size() > 0 && cyc >= cyc_q[0] + 2) begin
                $display("time %0t: no response for the request driven at cycle %0d",
                         $time, cyc_q[0]);
                errors++;
                e  = exp_q.pop_front();
                at = cyc_q.pop_front();
            end
        end
    end

    initial begin
        mem_pkg::mem_req_t    r;
        mem_pkg::tlb_result_t hit;
        mem_pkg::mem_op_e     st_ops[5];
        logic [31:0]          bases[4];
        int                   i;
        int                   j;
        void'($urandom(32'hf9e3_8176));
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        tlb       = '0;
        k0_cattr  = 3'd3;
        link_bit  = 1'b0;
        link_addr = '0;
        cyc = 0;
        errors = 0;
        checks = 0;
        tests = 0;
        failed_tests = 0;
        test_err0 = 0;
        hit    = mk_tlb(1'b1, 1'b1, 1'b1, 3'd3);
        st_ops = '{mem_pkg::op_sb, mem_pkg::op_sh, mem_pkg::op_sw,
                   mem_pkg::op_swl, mem_pkg::op_swr};
        bases  = '{32'h0040_1000, 32'h8000_2000, 32'ha000_3000, 32'hc000_4000};
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // unmapped segments
        check_val("rsp_valid", rsp_valid, 32'd0);
        send(mk_req(mem_pkg::op_lw, 32'h8012_3454, 32'h0), hit);
        send(mk_req(mem_pkg::op_sw, 32'ha012_3458, 32'h1111_2222), hit);
        end_test("unmapped_k3");
        k0_cattr = 3'd2;
        send(mk_req(mem_pkg::op_lb, 32'h9fff_fffd, 32'h0), hit);
        send(mk_req(mem_pkg::op_sb, 32'hbfc0_0001, 32'h55), hit);
        end_test("unmapped_k2");
        k0_cattr = 3'd3;

        // mapped, tlb cases
        send(mk_req(mem_pkg::op_lw, 32'h0040_1234, 32'h0), hit);
        send(mk_req(mem_pkg::op_sw, 32'he000_0010, 32'h5), mk_tlb(1'b1, 1'b1, 1'b1, 3'd2));
        send(mk_req(mem_pkg::op_lw, 32'h0040_1234, 32'h0), mk_tlb(1'b0, 1'b0, 1'b0, 3'd3));
        send(mk_req(mem_pkg::op_sw, 32'hc000_0040, 32'h7), mk_tlb(1'b0, 1'b1, 1'b1, 3'd3));
        send(mk_req(mem_pkg::op_lh, 32'h0040_1236, 32'h0), mk_tlb(1'b1, 1'b0, 1'b1, 3'd3));
        send(mk_req(mem_pkg::op_sb, 32'h0040_1237, 32'h9), mk_tlb(1'b1, 1'b0, 1'b1, 3'd3));
        send(mk_req(mem_pkg::op_sh, 32'h0040_1238, 32'h9), mk_tlb(1'b1, 1'b1, 1'b0, 3'd3));
        send(mk_req(mem_pkg::op_lw, 32'h0040_1238, 32'h0), mk_tlb(1'b1, 1'b1, 1'b0, 3'd3));
        end_test("mapped");

        // address errors and priority
        send(mk_req(mem_pkg::op_lh, 32'h8000_0011, 32'h0), hit);
        send(mk_req(mem_pkg::op_lhu, 32'h8000_0013, 32'h0), hit);
        send(mk_req(mem_pkg::op_lw, 32'h8000_0012, 32'h0), hit);
        send(mk_req(mem_pkg::op_ll, 32'h8000_0011, 32'h0), hit);
        send(mk_req(mem_pkg::op_sh, 32'h8000_0011, 32'h1), hit);
        send(mk_req(mem_pkg::op_sc, 32'h8000_0013, 32'h1), hit);
        send(mk_req(mem_pkg::op_swl, 32'h8000_0011, 32'h1), hit);
        send(mk_req(mem_pkg::op_sw, 32'h0040_1236, 32'h1), mk_tlb(1'b0, 1'b0, 1'b0, 3'd3));
        r = mk_req(mem_pkg::op_lw, 32'h8000_0012, 32'h0);
        r.interrupt = 1'b1;
        r.overflow  = 1'b1;
        send(r, hit);
        r = mk_req(mem_pkg::op_sw, 32'h8000_0012, 32'h0);
        r.prior_exc_valid = 1'b1;
        r.prior_exc_code  = mips_pkg::exc_tlbl;
        r.prior_refill    = 1'b1;
        r.overflow        = 1'b1;
        send(r, hit);
        r = mk_req(mem_pkg::op_lh, 32'h8000_0011, 32'h0);
        r.overflow = 1'b1;
        r.trap     = 1'b1;
        send(r, hit);
        r.overflow = 1'b0;
        send(r, hit);  // trap over adel
        end_test("addr_err");

        for (i = 0; i < 5; i++) begin
            for (j = 0; j < 4; j++) begin
                send(mk_req(st_ops[i], 32'h8000_0100 + j, 32'ha1b2_c3d4), hit);
            end
        end
        end_test("store_align");

        send(mk_req(mem_pkg::op_ll, 32'h8000_0200, 32'h0), hit);
        send(mk_req(mem_pkg::op_sc, 32'h8000_0200, 32'h1234_5678), hit);
        send(mk_req(mem_pkg::op_sc, 32'h8000_0200, 32'h1234_5678), hit);  // link already gone
        send(mk_req(mem_pkg::op_ll, 32'h8000_0200, 32'h0), hit);
        send(mk_req(mem_pkg::op_sc, 32'h8000_0204, 32'h1), hit);
        send(mk_req(mem_pkg::op_sc, 32'h8000_0200, 32'h1), hit);
        send(mk_req(mem_pkg::op_ll, 32'h8000_0200, 32'h0), hit);
        r = mk_req(mem_pkg::op_lw, 32'h8000_0300, 32'h0);
        r.overflow = 1'b1;
        send(r, hit);
        send(mk_req(mem_pkg::op_sc, 32'h8000_0200, 32'h1), hit);
        end_test("ll_sc");

        // back-to-back random stream
        for (i = 0; i < 200; i++) begin
            r = mk_req(mem_pkg::mem_op_e'(4'($urandom_range(0, 12))),
                       bases[$urandom_range(0, 3)] + $urandom_range(0, 7), $urandom);
            r.pc              = $urandom;
            r.interrupt       = ($urandom_range(0, 31) == 0);
            r.overflow        = ($urandom_range(0, 31) == 0);
            r.trap            = ($urandom_range(0, 31) == 0);
            r.prior_exc_valid = ($urandom_range(0, 31) == 0);
            r.prior_exc_code  = ($urandom_range(0, 1) != 0) ? mips_pkg::exc_adel
                                                             : mips_pkg::exc_tlbl;
            r.prior_refill    = $urandom_range(0, 1);
            send(r, mk_tlb($urandom_range(0, 7) != 0, $urandom_range(0, 7) != 0,
                           $urandom_range(0, 3) != 0,
                           ($urandom_range(0, 3) != 0) ? 3'd3 : 3'd2));
        end
        end_test("random");

        $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests, failed_tests, checks, errors, u_mem_stage_top.u_mem_stage_sva.fail_cnt);
        if (errors == 0 && u_mem_stage_top.u_mem_stage_sva.fail_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* files.f */
src/mips_pkg.sv
src/mem_pkg.sv
src/addr_translate.sv
src/exc_detect.sv
src/ll_sc_monitor.sv
src/store_align.sv
src/mem_resp_reg.sv
src/mem_stage_top.sv
tb/mem_stage_sva.sv
tb/tb_mem_stage.sv

/* Bender.yml */
package:
  name: mem_stage

sources:
  - files:
      - src/mips_pkg.sv
      - src/mem_pkg.sv
      - src/addr_translate.sv
      - src/exc_detect.sv
      - src/ll_sc_monitor.sv
      - src/store_align.sv
      - src/mem_resp_reg.sv
      - src/mem_stage_top.sv
  - target: test
    files:
      - tb/mem_stage_sva.sv
      - tb/tb_mem_stage.sv
